/* Bender.yml */
package:
  name: exc_cp0

export_include_dirs:
  - logic

sources:
  - logic/cpu_pkg.sv
  - logic/exc_handler.sv
  - logic/cp0_regs.sv
  - logic/exc_top.sv
  - target: test
    files:
      - verification/exc_assertions.sv
      - verification/exc_tb.sv

/* exc_cp0.f */
+incdir+logic
logic/cpu_pkg.sv
logic/exc_handler.sv
logic/cp0_regs.sv
logic/exc_top.sv
verification/exc_assertions.sv
verification/exc_tb.sv

/* logic/cp0_regs.sv */
`default_nettype none

`include "cpu_defs.svh"

module cp0_regs
    import cpu_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  cp0_op_t     cp0_op,
    input  exc_info_t   exc_info,
    input  cp0_wr_t     mtc0,
    input  logic [5:0]  hw_int,
    input  logic [4:0]  rd_addr,
    output logic [31:0] rd_data,
    output cp0_view_t   cp0_view
);

    // software writable fields
    localparam logic [31:0] STATUS_WMASK = 32'h0000_FF03;   // IM, EXL, IE
    localparam logic [31:0] CAUSE_WMASK  = 32'h0000_0300;   // IP[1:0]

    logic [31:0] status_q, status_d;
    logic [31:0] cause_q, cause_d;
    logic [31:0] epc_q, epc_d;
    logic [31:0] badvaddr_q, badvaddr_d;
    logic [31:0] count_q, count_d;
    logic [31:0] compare_q, compare_d;

    logic mtc0_hit;
    logic exc_take;
    logic timer_hit;

    // mtc0 only when the handler lets it through
    assign mtc0_hit  = (cp0_op == MTC0) && mtc0.wen;
    assign exc_take  = (cp0_op == EXC) || (cp0_op == BADVA);
    // compare of zero means timer off
    assign timer_hit = (count_q == compare_q) && (compare_q != 32'd0);

    //////////////////////////////
    // next state
    //////////////////////////////

    always_comb begin
        status_d   = status_q;
        cause_d    = cause_q;
        epc_d      = epc_q;
        badvaddr_d = badvaddr_q;
        compare_d  = compare_q;
        // free running counter
        count_d    = count_q + 32'd1;

        // hw lines into IP7..IP2 with TI also on IP7
        cause_d[15:10] = hw_int | {cause_q[30], 5'b0};

        // TI set on match and cleared below by a compare write
        if (timer_hit) begin
            cause_d[30] = 1'b1;
        end

        if (exc_take) begin
            status_d[1]   = 1'b1;
            epc_d         = exc_info.epc;
            cause_d[31]   = exc_info.cause_bd;
            cause_d[6:2]  = exc_info.cause_exccode;
            if (cp0_op == BADVA) begin
                badvaddr_d = exc_info.badvaddr;
            end
        end else if (cp0_op == ERET) begin
            status_d[1] = 1'b0;
        end else if (mtc0_hit) begin
            case (mtc0.addr)
                `CP0_STATUS: status_d = (status_q & ~STATUS_WMASK)
                                      | (mtc0.data & STATUS_WMASK);
                `CP0_CAUSE: cause_d = (cause_d & ~CAUSE_WMASK)
                                    | (mtc0.data & CAUSE_WMASK);
                `CP0_EPC: epc_d = mtc0.data;
                `CP0_COUNT: count_d = mtc0.data;
                `CP0_COMPARE: begin
                    compare_d   = mtc0.data;
                    // acknowledge timer interrupt
                    cause_d[30] = 1'b0;
                end
                default: ;
            endcase
        end
    end

    //////////////////////////////
    // state registers
    //////////////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            status_q   <= `STATUS_RESET;
            cause_q    <= 32'd0;
            epc_q      <= 32'd0;
            badvaddr_q <= 32'd0;
            count_q    <= 32'd0;
            compare_q  <= 32'd0;
        end else begin
            status_q   <= status_d;
            cause_q    <= cause_d;
            epc_q      <= epc_d;
            badvaddr_q <= badvaddr_d;
            count_q    <= count_d;
            compare_q  <= compare_d;
        end
    end

    // mfc0 read port with unknown numbers reading zero
    always_comb begin
        case (rd_addr)
            `CP0_BADVADDR: rd_data = badvaddr_q;
            `CP0_COUNT:    rd_data = count_q;
            `CP0_COMPARE:  rd_data = compare_q;
            `CP0_STATUS:   rd_data = status_q;
            `CP0_CAUSE:    rd_data = cause_q;
            `CP0_EPC:      rd_data = epc_q;
            default:       rd_data = 32'd0;
        endcase
    end

    // handler view
    assign cp0_view.status = status_q;
    assign cp0_view.cause  = cause_q;
    assign cp0_view.epc    = epc_q;

endmodule

`default_nettype wire

/* logic/cpu_defs.svh */
`ifndef CPU_DEFS_SVH
`define CPU_DEFS_SVH

//////////////////////////////
// Cause.ExcCode values
//////////////////////////////

// interrupt
`define EXCCODE_INT  5'd0
// address error on fetch or load
`define EXCCODE_ADEL 5'd4
// address error on store
`define EXCCODE_ADES 5'd5
`define EXCCODE_SYS  5'd8
`define EXCCODE_BP   5'd9
// reserved instruction
`define EXCCODE_RI   5'd10
// integer overflow
`define EXCCODE_OV   5'd12

//////////////////////////////
// CP0 register numbers
//////////////////////////////

`define CP0_BADVADDR 5'd8
`define CP0_COUNT    5'd9
`define CP0_COMPARE  5'd11
`define CP0_STATUS   5'd12
`define CP0_CAUSE    5'd13
`define CP0_EPC      5'd14

// general exception entry, BEV=1 space
`define EXC_VECTOR   32'hBFC0_0380

// only BEV (bit 22) set out of reset
`define STATUS_RESET 32'h0040_0000

`endif

/* logic/cpu_pkg.sv */
`default_nettype none

package cpu_pkg;

    //////////////////////////////
    // CP0 update selector
    //////////////////////////////

    // one update per cycle, chosen by the handler
    typedef enum logic [2:0] {
        NONE  = 3'd0,
        EXC   = 3'd1,
        BADVA = 3'd2,   // exception that also loads BadVAddr
        ERET  = 3'd3,
        MTC0  = 3'd4
    } cp0_op_t;

    //////////////////////////////
    // records between stages
    //////////////////////////////

    // memory stage flags for one instruction
    typedef struct packed {
        logic        is_instr;
        logic        in_delay_slot;
        logic [31:0] pc;
        logic [31:0] badvaddr;
        logic [1:0]  addr_err;       // 01 fetch, 10 load, 11 store
        logic        reserved_instr;
        logic        intovf;
        logic        brk;
        logic        syscall;
        logic        eret;
    } mem_exc_t;

    // mtc0 request from the pipeline
    typedef struct packed {
        logic        wen;
        logic [4:0]  addr;
        logic [31:0] data;
    } cp0_wr_t;

    // values written into CP0 on an exception
    typedef struct packed {
        logic [31:0] epc;
        logic        cause_bd;
        logic [4:0]  cause_exccode;
        logic [31:0] badvaddr;
    } exc_info_t;

    // CP0 state the handler looks at
    typedef struct packed {
        logic [31:0] status;
        logic [31:0] cause;
        logic [31:0] epc;
    } cp0_view_t;

endpackage

`default_nettype wire

/* logic/exc_handler.sv */
`default_nettype none

`include "cpu_defs.svh"

module exc_handler
    import cpu_pkg::*;
(
    input  mem_exc_t    mem,
    input  logic        mtc0_wen,
    input  cp0_view_t   cp0_view,
    output cp0_op_t     cp0_op,
    output exc_info_t   exc_info,
    output logic        flush,
    output logic [31:0] redirect_pc
);

    logic        exl;
    logic        int_pending;
    logic        exc_valid;
    logic [4:0]  exccode;
    logic [31:0] pc_minus4;

    // status bit 1 is EXL, bit 0 is IE
    assign exl = cp0_view.status[1];

    // epc target for a delay slot instruction
    assign pc_minus4 = mem.pc - 32'd4;

    // IP vs IM, globally enabled, not already in a handler
    assign int_pending = (|(cp0_view.cause[15:8] & cp0_view.status[15:8]))
                         && cp0_view.status[0] && !exl;

    //////////////////////////////
    // priority encoder
    //////////////////////////////

    always_comb begin
        exc_valid = 1'b0;
        exccode   = 5'd0;
        cp0_op    = NONE;
        // bubbles never raise anything
        if (!mem.is_instr) begin
            cp0_op = NONE;
        end else if (int_pending) begin
            exc_valid = 1'b1;
            exccode   = `EXCCODE_INT;
            cp0_op    = EXC;
        end else if (mem.addr_err == 2'b01) begin
            // fetch side address error
            exc_valid = 1'b1;
            exccode   = `EXCCODE_ADEL;
            cp0_op    = BADVA;
        end else if (mem.reserved_instr) begin
            exc_valid = 1'b1;
            exccode   = `EXCCODE_RI;
            cp0_op    = EXC;
        end else if (mem.intovf) begin
            exc_valid = 1'b1;
            exccode   = `EXCCODE_OV;
            cp0_op    = EXC;
        end else if (mem.brk) begin
            exc_valid = 1'b1;
            exccode   = `EXCCODE_BP;
            cp0_op    = EXC;
        end else if (mem.syscall) begin
            exc_valid = 1'b1;
            exccode   = `EXCCODE_SYS;
            cp0_op    = EXC;
        end else if (mem.addr_err == 2'b10) begin
            // load address error
            exc_valid = 1'b1;
            exccode   = `EXCCODE_ADEL;
            cp0_op    = BADVA;
        end else if (mem.addr_err == 2'b11) begin
            // store address error
            exc_valid = 1'b1;
            exccode   = `EXCCODE_ADES;
            cp0_op    = BADVA;
        end else if (mem.eret) begin
            cp0_op = ERET;
        end else if (mtc0_wen) begin
            cp0_op = MTC0;
        end
    end

    //////////////////////////////
    // epc and branch delay bit
    //////////////////////////////

    always_comb begin
        exc_info.cause_exccode = exccode;
        exc_info.badvaddr      = mem.badvaddr;
        // nested exception keeps the first epc
        if (exl) begin
            exc_info.epc      = cp0_view.epc;
            exc_info.cause_bd = cp0_view.cause[31];
        end else if (mem.in_delay_slot) begin
            exc_info.epc      = pc_minus4;
            exc_info.cause_bd = 1'b1;
        end else begin
            exc_info.epc      = mem.pc;
            exc_info.cause_bd = 1'b0;
        end
    end

    // redirect on exception entry or return
    assign flush = exc_valid || (cp0_op == ERET);

    always_comb begin
        if (exc_valid) begin
            redirect_pc = `EXC_VECTOR;
        end else if (cp0_op == ERET) begin
            redirect_pc = cp0_view.epc;
        end else begin
            redirect_pc = 32'd0;
        end
    end

endmodule

`default_nettype wire

/* logic/exc_top.sv */
`default_nettype none

module exc_top
    import cpu_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  mem_exc_t    mem,
    input  cp0_wr_t     mtc0,
    input  logic [5:0]  hw_int,
    input  logic [4:0]  rd_addr,
    output logic [31:0] rd_data,
    output logic        flush,
    output logic [31:0] redirect_pc
);

    //////////////////////////////
    // handler to cp0 wiring
    //////////////////////////////

    cp0_op_t   cp0_op;
    exc_info_t exc_info;
    cp0_view_t cp0_view;

    // decision is combinational in the mem cycle
    exc_handler u_exc_handler (
        .mem         (mem),
        .mtc0_wen    (mtc0.wen),
        .cp0_view    (cp0_view),
        .cp0_op      (cp0_op),
        .exc_info    (exc_info),
        .flush       (flush),
        .redirect_pc (redirect_pc)
    );

    // updates land on the next edge
    cp0_regs u_cp0_regs (
        .clk      (clk),
        .rst_n    (rst_n),
        .cp0_op   (cp0_op),
        .exc_info (exc_info),
        .mtc0     (mtc0),
        .hw_int   (hw_int),
        .rd_addr  (rd_addr),
        .rd_data  (rd_data),
        .cp0_view (cp0_view)
    );

endmodule

`default_nettype wire

/* verification/exc_assertions.sv */
`default_nettype none

module exc_assertions
    import cpu_pkg::*;
(
    input logic        clk,
    input logic        rst_n,
    input cp0_op_t     cp0_op,
    input logic [31:0] status,
    input logic [31:0] badvaddr
);

    // failed assertions so far
    int unsigned fail_count = 0;

    //////////////////////////////
    // cp0 state rules
    //////////////////////////////

    // exception entry always lands in EXL
    exl_after_exc: assert property (@(posedge clk) disable iff (!rst_n)
        (cp0_op == EXC || cp0_op == BADVA) |=> status[1])
        else begin
            fail_count++;
            $error("EXL not set in the cycle after an exception");
        end

    // only an address error loads badvaddr
    badva_hold: assert property (@(posedge clk) disable iff (!rst_n)
        (cp0_op != BADVA) |=> $stable(badvaddr))
        else begin
            fail_count++;
            $error("BadVAddr changed without an address error");
        end

    // BEV stays at its reset value
    bev_fixed: assert property (@(posedge clk) disable iff (!rst_n)
        status[22] == 1'b1)
        else begin
            fail_count++;
            $error("Status.BEV changed");
        end

endmodule

bind cp0_regs exc_assertions u_exc_assertions (
    .clk      (clk),
    .rst_n    (rst_n),
    .cp0_op   (cp0_op),
    .status   (status_q),
    .badvaddr (badvaddr_q)
);

`default_nettype wire

/* verification/exc_tb.sv */
`default_nettype none

`include "cpu_defs.svh"

module exc_tb
    import cpu_pkg::*;
();

    // test lengths in cycles
    localparam int N_FLAGS      = 400;
    localparam int N_MTC0       = 300;
    localparam int N_IRQ        = 400;
    localparam int TIMER_ROUNDS = 8;
    localparam int TIMER_CYC    = 44;
    localparam int TOTAL_CYC    = 12 + N_FLAGS + N_MTC0 + N_IRQ + TIMER_ROUNDS * TIMER_CYC;
    localparam int CYCLE_LIMIT  = 2 * TOTAL_CYC;

    // IM, EXL and IE
    localparam logic [31:0] STATUS_SW = 32'h0000_FF03;

    logic        clk;
    logic        rst_n;
    mem_exc_t    mem;
    cp0_wr_t     mtc0;
    logic [5:0]  hw_int;
    logic [4:0]  rd_addr;
    logic [31:0] rd_data;
    logic        flush;
    logic [31:0] redirect_pc;
    int unsigned cycles;

    // reference CP0 state
    logic [31:0] m_status, m_cause, m_epc, m_badva, m_count, m_compare;

    exc_top UUT (
        .clk         (clk),
        .rst_n       (rst_n),
        .mem         (mem),
        .mtc0        (mtc0),
        .hw_int      (hw_int),
        .rd_addr     (rd_addr),
        .rd_data     (rd_data),
        .flush       (flush),
        .redirect_pc (redirect_pc)
    );

    always #5 clk = ~clk;

    // watchdog
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("Timeout: the run went past %0d cycles without finishing", CYCLE_LIMIT);
            abort_run();
        end
    end

    // failures flagged by the bound checker
    always @(negedge clk) begin
        if (UUT.u_cp0_regs.u_exc_assertions.fail_count != 0) begin
            $display("Error: time %0t, an assertion on the CP0 registers failed", $time);
            abort_run();
        end
    end

    //////////////////////////////
    // checks
    //////////////////////////////

    task automatic abort_run();
        $display("Result: FAILED");
        $fatal(1);
    endtask

    task automatic report_value(input string name, input logic [31:0] exp, input logic [31:0] got);
        $display("Error: time %0t, %s expected %h, got %h", $time, name, exp, got);
        abort_run();
    endtask

    task automatic check_redirect(input logic exp_flush, input logic [31:0] exp_pc);
        if (flush !== exp_flush) begin
            report_value("flush", {31'd0, exp_flush}, {31'd0, flush});
        end
        // target only matters while flushing
        if (exp_flush && redirect_pc !== exp_pc) begin
            report_value("redirect_pc", exp_pc, redirect_pc);
        end
    endtask

    task automatic check_rdata(input logic [31:0] exp);
        if (rd_data !== exp) begin
            report_value("rd_data", exp, rd_data);
        end
    endtask

    task automatic check_op(input cp0_op_t exp);
        cp0_op_t got;
        got = UUT.cp0_op;
        if (got !== exp) begin
            $display("Error: time %0t, cp0_op expected %s, got %s", $time, exp.name(), got.name());
            abort_run();
        end
    endtask

    //////////////////////////////
    // reference model
    //////////////////////////////

    // lowest rank first so higher causes overwrite
    function automatic cp0_op_t predict_op(input mem_exc_t m, input logic wen,
                                           output logic [4:0] code);
        cp0_op_t op;
        logic    irq;
        irq  = (|(m_cause[15:8] & m_status[15:8])) && m_status[0] && !m_status[1];
        op   = NONE;
        code = 5'd0;
        if (wen) begin
            op = MTC0;
        end
        if (m.eret) begin
            op = ERET;
        end
        if (m.addr_err == 2'b11) begin
            op   = BADVA;
            code = `EXCCODE_ADES;
        end
        if (m.addr_err == 2'b10) begin
            op   = BADVA;
            code = `EXCCODE_ADEL;
        end
        if (m.syscall) begin
            op   = EXC;
            code = `EXCCODE_SYS;
        end
        if (m.brk) begin
            op   = EXC;
            code = `EXCCODE_BP;
        end
        if (m.intovf) begin
            op   = EXC;
            code = `EXCCODE_OV;
        end
        if (m.reserved_instr) begin
            op   = EXC;
            code = `EXCCODE_RI;
        end
        // fetch error ranks above RI
        if (m.addr_err == 2'b01) begin
            op   = BADVA;
            code = `EXCCODE_ADEL;
        end
        if (irq) begin
            op   = EXC;
            code = `EXCCODE_INT;
        end
        if (!m.is_instr) begin
            op = NONE;
        end
        return op;
    endfunction

    function automatic logic [31:0] read_model(input logic [4:0] addr);
        case (addr)
            `CP0_BADVADDR: return m_badva;
            `CP0_COUNT:    return m_count;
            `CP0_COMPARE:  return m_compare;
            `CP0_STATUS:   return m_status;
            `CP0_CAUSE:    return m_cause;
            `CP0_EPC:      return m_epc;
            default:       return 32'd0;
        endcase
    endfunction

    // state after the coming edge
    task automatic advance_model(input cp0_op_t op, input logic [4:0] code);
        logic [31:0] nx_cause;
        nx_cause = m_cause;
        // IP7 picks up last cycle's TI
        nx_cause[15:10] = hw_int | {m_cause[30], 5'b0};
        if (m_compare != 32'd0 && m_count == m_compare) begin
            nx_cause[30] = 1'b1;
        end
        m_count = m_count + 32'd1;
        case (op)
            EXC, BADVA: begin
                if (!m_status[1]) begin
                    nx_cause[31] = mem.in_delay_slot;
                    m_epc = mem.in_delay_slot ? mem.pc - 32'd4 : mem.pc;
                end
                nx_cause[6:2] = code;
                m_status[1]   = 1'b1;
                if (op == BADVA) begin
                    m_badva = mem.badvaddr;
                end
            end
            ERET: m_status[1] = 1'b0;
            MTC0: begin
                case (mtc0.addr)
                    `CP0_STATUS:  m_status = (m_status & ~STATUS_SW) | (mtc0.data & STATUS_SW);
                    `CP0_CAUSE:   nx_cause[9:8] = mtc0.data[9:8];
                    `CP0_EPC:     m_epc = mtc0.data;
                    `CP0_COUNT:   m_count = mtc0.data;
                    `CP0_COMPARE: begin
                        m_compare    = mtc0.data;
                        nx_cause[30] = 1'b0;
                    end
                    default: ;
                endcase
            end
            default: ;
        endcase
        m_cause = nx_cause;
    endtask

    // compare the current cycle and then step the model
    task automatic evaluate();
        cp0_op_t    op;
        logic [4:0] code;
        op = predict_op(mem, mtc0.wen, code);
        check_op(op);
        check_redirect(op == EXC || op == BADVA || op == ERET,
                       (op == ERET) ? m_epc : `EXC_VECTOR);
        check_rdata(read_model(rd_addr));
        advance_model(op, code);
    endtask

    //////////////////////////////
    // stimulus
    //////////////////////////////

    task automatic step(input mem_exc_t m, input cp0_wr_t w, input logic [5:0] hw,
                        input logic [4:0] ra);
        @(posedge clk);
        mem     <= m;
        mtc0    <= w;
        hw_int  <= hw;
        rd_addr <= ra;
        @(negedge clk);
        evaluate();
    endtask

    function automatic mem_exc_t plain_instr();
        mem_exc_t r;
        r          = '0;
        r.is_instr = 1'b1;
        r.pc       = {30'($urandom), 2'b00};
        r.badvaddr = $urandom;
        return r;
    endfunction

    // each flag set about once in rate records
    function automatic mem_exc_t rand_record(input int unsigned rate);
        mem_exc_t r;
        r                = plain_instr();
        r.is_instr       = ($urandom % 8) != 0;
        r.in_delay_slot  = 1'($urandom);
        r.addr_err       = (($urandom % rate) == 0) ? 2'($urandom) : 2'b00;
        r.reserved_instr = ($urandom % rate) == 0;
        r.intovf         = ($urandom % rate) == 0;
        r.brk            = ($urandom % rate) == 0;
        r.syscall        = ($urandom % rate) == 0;
        r.eret           = ($urandom % rate) == 0;
        return r;
    endfunction

    function automatic cp0_wr_t make_write(input logic [4:0] addr, input logic [31:0] data);
        return '{wen: 1'b1, addr: addr, data: data};
    endfunction

    // six registers plus an unused number
    function automatic logic [4:0] pick_reg();
        case ($urandom % 7)
            0:       return `CP0_BADVADDR;
            1:       return `CP0_COUNT;
            2:       return `CP0_COMPARE;
            3:       return `CP0_STATUS;
            4:       return `CP0_CAUSE;
            5:       return `CP0_EPC;
            default: return 5'd3;
        endcase
    endfunction

    initial begin
        logic [4:0]  last_addr;
        logic [7:0]  im;
        logic [31:0] delta;
        clk       = 1'b0;
        rst_n     = 1'b0;
        mem       = '0;
        mtc0      = '0;
        hw_int    = 6'd0;
        rd_addr   = `CP0_STATUS;
        cycles    = 0;
        void'($urandom(32'h3d708de5));
        m_status  = `STATUS_RESET;
        m_cause   = 32'd0;
        m_epc     = 32'd0;
        m_badva   = 32'd0;
        m_count   = 32'd0;
        m_compare = 32'd0;
        repeat (10) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        evaluate();

        // flag mix with IE still clear so no interrupts
        repeat (N_FLAGS) begin
            step(rand_record(5), '0, 6'($urandom), ($urandom % 2) ? `CP0_CAUSE : pick_reg());
        end

        // mtc0 then mfc0 of the same number
        last_addr = `CP0_STATUS;
        repeat (N_MTC0) begin
            mem_exc_t    r;
            logic [4:0]  addr;
            r    = plain_instr();
            addr = pick_reg();
            // occasional address error for badvaddr
            if (($urandom % 8) == 0) begin
                r.addr_err = 2'($urandom % 3 + 1);
            end
            step(r, make_write(addr, $urandom), 6'd0, last_addr);
            last_addr = addr;
        end

        // interrupts enabled with random IM
        for (int i = 0; i < N_IRQ; i++) begin
            if (i % 20 == 0) begin
                im = 8'($urandom);
                step(plain_instr(), make_write(`CP0_STATUS, {16'd0, im, 8'h01}), 6'($urandom),
                     `CP0_STATUS);
            end else begin
                step(rand_record(4), '0, 6'($urandom),
                     ($urandom % 2) ? `CP0_CAUSE : pick_reg());
            end
        end

        // timer with interrupts off
        step(plain_instr(), make_write(`CP0_STATUS, 32'd0), 6'd0, `CP0_STATUS);
        repeat (TIMER_ROUNDS) begin
            delta = 4 + ($urandom % 32);
            step(plain_instr(), make_write(`CP0_COUNT, $urandom), 6'd0, `CP0_COUNT);
            step(plain_instr(), make_write(`CP0_COMPARE, m_count + delta), 6'd0, `CP0_COMPARE);
            repeat (delta + 4) begin
                step('0, '0, 6'd0, `CP0_CAUSE);
            end
            // compare write acknowledges TI
            step(plain_instr(), make_write(`CP0_COMPARE, $urandom), 6'd0, `CP0_CAUSE);
            step('0, '0, 6'd0, `CP0_CAUSE);
        end

        if (UUT.u_cp0_regs.u_exc_assertions.fail_count != 0) begin
            $display("An assertion on the CP0 registers failed during the run");
            abort_run();
        end else begin
            $display("Result: PASSED");
            $finish;
        end
    end

endmodule

`default_nettype wire
